//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/1ns
TOP       = tb_core_top
FILELIST  = sim.f
PASS_MSG  = Simulation finished: PASS

.PHONY: sim clean

# build, run, then look for the pass line in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf obj_dir

//--- common/core_pkg.sv
/*
 * core package
 * bridge address map, bus widths, save-size settings and the
 * video word shared by the settings, control and video blocks
 */

`default_nettype none

package core_pkg;

  ////////////////////////////////////////
  // bus types

  typedef logic [31:0] bridge_addr_t;
  typedef logic [31:0] bridge_data_t;
  typedef logic [9:0]  datatable_addr_t;
  typedef logic [15:0] slot_id_t;

  // core dot clock code, 0..3
  typedef logic [1:0]  dotclock_t;

  ////////////////////////////////////////
  // bridge write addresses

  localparam bridge_addr_t addr_sgx       = 32'h0000_0004;
  localparam bridge_addr_t addr_core_hold = 32'h0000_0050;
  localparam bridge_addr_t addr_overscan  = 32'h0000_0100;
  localparam bridge_addr_t addr_border    = 32'h0000_0104;
  localparam bridge_addr_t addr_mb128     = 32'h0000_0200;

  // read regions, matched on the upper address bits
  localparam logic [3:0] region_save = 4'h2;
  localparam logic [7:0] region_cmd  = 8'hF8;

  ////////////////////////////////////////
  // data table

  // advertised save size, normal and 128 KB
  localparam bridge_data_t save_size_small = 32'h0000_0800;
  localparam bridge_data_t save_size_large = 32'h0002_0000;

  // slot index 1 -> entry 1*2+1
  localparam datatable_addr_t datatable_save_entry = 10'd3;

  localparam slot_id_t save_slot_id = 16'd1;

  ////////////////////////////////////////
  // video word, colour or end of line

  typedef union packed {
    struct packed {
      logic [7:0] r;
      logic [7:0] g;
      logic [7:0] b;
    } colour;
    struct packed {
      logic [7:0]  zero_hi;
      logic [1:0]  slot;
      logic        overscan;
      logic [12:0] zero_lo;
    } eol;
  } video_word_t;

endpackage

`default_nettype wire

//--- hdl/bridge_settings.sv
/*
 * bridge settings
 * decodes host bridge writes into core settings, muxes bridge
 * reads by region and keeps the save-size data-table entry current
 */

`timescale 1ns/1ns
`default_nettype none

module bridge_settings (
  input  wire                            clk_74a,
  input  wire                            pll_core_locked,
  input  core_pkg::bridge_addr_t         bridge_addr,
  input  wire                            bridge_wr,
  input  core_pkg::bridge_data_t         bridge_wr_data,
  input  core_pkg::bridge_data_t         save_rd_data,
  input  core_pkg::bridge_data_t         cmd_rd_data,
  output core_pkg::bridge_data_t         bridge_rd_data,
  output logic                           sgx,
  output logic                           overscan,
  output logic                           border,
  output logic                           hold_start,
  output core_pkg::datatable_addr_t      datatable_addr,
  output core_pkg::bridge_data_t         datatable_data,
  output logic                           datatable_wren
);

  logic mb128;

  ////////////////////////////////////////
  // read mux

  always_comb begin
    if (bridge_addr[31:28] == core_pkg::region_save) begin
      bridge_rd_data = save_rd_data;
    end else if (bridge_addr[31:24] == core_pkg::region_cmd) begin
      bridge_rd_data = cmd_rd_data;
    end else begin
      bridge_rd_data = '0;
    end
  end

  ////////////////////////////////////////
  // setting bits, bit 0 of write data

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      sgx        <= 1'b0;
      overscan   <= 1'b0;
      border     <= 1'b0;
      mb128      <= 1'b0;
      hold_start <= 1'b0;
    end else begin
      // one cycle pulse to the hold timer
      hold_start <= bridge_wr && (bridge_addr == core_pkg::addr_core_hold);
      if (bridge_wr) begin
        case (bridge_addr)
          core_pkg::addr_sgx:      sgx      <= bridge_wr_data[0];
          core_pkg::addr_overscan: overscan <= bridge_wr_data[0];
          core_pkg::addr_border:   border   <= bridge_wr_data[0];
          core_pkg::addr_mb128:    mb128    <= bridge_wr_data[0];
          default: ;
        endcase
      end
    end
  end

  ////////////////////////////////////////
  // save size entry, rewritten every cycle

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      datatable_wren <= 1'b0;
      datatable_addr <= '0;
      datatable_data <= '0;
    end else begin
      datatable_wren <= 1'b1;
      datatable_addr <= core_pkg::datatable_save_entry;
      datatable_data <= mb128 ? core_pkg::save_size_large : core_pkg::save_size_small;
    end
  end

endmodule

`default_nettype wire

//--- hdl/core_control_fsm.sv
/*
 * core control FSM
 * holds the emulated core in reset, runs it, tracks cart download
 * and flags save-slot traffic from the data-slot ids
 */

`timescale 1ns/1ns
`default_nettype none

module core_control_fsm (
  input  wire                 clk_74a,
  input  wire                 pll_core_locked,
  input  wire                 host_reset_n,
  input  wire                 hold_busy,
  input  wire                 dataslot_requestwrite,
  input  wire                 dataslot_allcomplete,
  input  core_pkg::slot_id_t  dataslot_requestwrite_id,
  input  core_pkg::slot_id_t  dataslot_requestread_id,
  output logic                core_reset,
  output logic                cart_download,
  output logic                save_loading
);

  localparam logic [1:0] st_hold     = 2'd0;
  localparam logic [1:0] st_run      = 2'd1;
  localparam logic [1:0] st_download = 2'd2;

  logic [1:0] state;
  logic [1:0] state_next;

  ////////////////////////////////////////
  // next state

  always_comb begin
    state_next = state;
    if (!host_reset_n || hold_busy) begin
      // host reset or hold timer wins from any state
      state_next = st_hold;
    end else begin
      case (state)
        st_hold:     state_next = st_run;
        st_run:      if (dataslot_requestwrite) state_next = st_download;
        st_download: if (dataslot_allcomplete) state_next = st_run;
        default:     state_next = st_hold;
      endcase
    end
  end

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      state <= st_hold;
    end else begin
      state <= state_next;
    end
  end

  assign core_reset    = (state == st_hold);
  assign cart_download = (state == st_download);

  // save traffic on either slot direction
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      save_loading <= 1'b0;
    end else begin
      save_loading <= (dataslot_requestwrite_id == core_pkg::save_slot_id) ||
                      (dataslot_requestread_id == core_pkg::save_slot_id);
    end
  end

endmodule

`default_nettype wire

//--- hdl/core_hold_timer.sv
/*
 * core hold timer
 * down-counter loaded on a hold request, busy while non-zero
 */

`timescale 1ns/1ns
`default_nettype none

module core_hold_timer #(
  parameter logic [31:0] HOLD_CYCLES = 32'h0010_0000
) (
  input  wire  clk_74a,
  input  wire  pll_core_locked,
  input  wire  hold_start,
  output logic hold_busy
);

  logic [31:0] count;

  // a new request reloads, even mid count
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      count <= '0;
    end else if (hold_start) begin
      count <= HOLD_CYCLES;
    end else if (count != '0) begin
      count <= count - 32'd1;
    end
  end

  assign hold_busy = (count != '0);

endmodule

`default_nettype wire

//--- hdl/core_top.sv
/*
 * core top level
 * connects bridge settings, hold timer, control FSM and video output
 */

`timescale 1ns/1ns
`default_nettype none

module core_top #(
  parameter logic [31:0] HOLD_CYCLES = 32'h0010_0000,
  parameter logic [2:0]  HS_DELAY    = 3'd6
) (
  input  wire                        clk_74a,
  input  wire                        pll_core_locked,

  // host bridge
  input  core_pkg::bridge_addr_t     bridge_addr,
  input  wire                        bridge_wr,
  input  core_pkg::bridge_data_t     bridge_wr_data,
  output core_pkg::bridge_data_t     bridge_rd_data,
  input  core_pkg::bridge_data_t     save_rd_data,
  input  core_pkg::bridge_data_t     cmd_rd_data,

  // settings and data table
  output wire                        sgx,
  output wire                        overscan,
  output wire                        border,
  output core_pkg::datatable_addr_t  datatable_addr,
  output core_pkg::bridge_data_t     datatable_data,
  output wire                        datatable_wren,

  // host command handler
  input  wire                        host_reset_n,
  input  wire                        dataslot_requestwrite,
  input  wire                        dataslot_allcomplete,
  input  core_pkg::slot_id_t         dataslot_requestwrite_id,
  input  core_pkg::slot_id_t         dataslot_requestread_id,
  output wire                        core_reset,
  output wire                        cart_download,
  output wire                        save_loading,

  // core video in, scaler video out
  input  wire                        hblank,
  input  wire                        vblank,
  input  wire                        border_active,
  input  wire                        hsync_core,
  input  wire                        vsync_core,
  input  core_pkg::video_word_t      rgb_core,
  input  core_pkg::dotclock_t        dotclock_divider,
  output core_pkg::video_word_t      video_rgb,
  output wire                        video_de,
  output wire                        video_hs,
  output wire                        video_vs
);

  wire hold_start;
  wire hold_busy;

  bridge_settings u_bridge_settings (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .bridge_addr     (bridge_addr),
    .bridge_wr       (bridge_wr),
    .bridge_wr_data  (bridge_wr_data),
    .save_rd_data    (save_rd_data),
    .cmd_rd_data     (cmd_rd_data),
    .bridge_rd_data  (bridge_rd_data),
    .sgx             (sgx),
    .overscan        (overscan),
    .border          (border),
    .hold_start      (hold_start),
    .datatable_addr  (datatable_addr),
    .datatable_data  (datatable_data),
    .datatable_wren  (datatable_wren)
  );

  core_hold_timer #(
    .HOLD_CYCLES (HOLD_CYCLES)
  ) u_core_hold_timer (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .hold_start      (hold_start),
    .hold_busy       (hold_busy)
  );

  core_control_fsm u_core_control_fsm (
    .clk_74a                  (clk_74a),
    .pll_core_locked          (pll_core_locked),
    .host_reset_n             (host_reset_n),
    .hold_busy                (hold_busy),
    .dataslot_requestwrite    (dataslot_requestwrite),
    .dataslot_allcomplete     (dataslot_allcomplete),
    .dataslot_requestwrite_id (dataslot_requestwrite_id),
    .dataslot_requestread_id  (dataslot_requestread_id),
    .core_reset               (core_reset),
    .cart_download            (cart_download),
    .save_loading             (save_loading)
  );

  video_output #(
    .HS_DELAY (HS_DELAY)
  ) u_video_output (
    .clk_74a          (clk_74a),
    .pll_core_locked  (pll_core_locked),
    .hblank           (hblank),
    .vblank           (vblank),
    .border_active    (border_active),
    .hsync_core       (hsync_core),
    .vsync_core       (vsync_core),
    .rgb_core         (rgb_core),
    .overscan         (overscan),
    .dotclock_divider (dotclock_divider),
    .video_rgb        (video_rgb),
    .video_de         (video_de),
    .video_hs         (video_hs),
    .video_vs         (video_vs)
  );

endmodule

`default_nettype wire

//--- sim.f
+incdir+sim
common/core_pkg.sv
hdl/bridge_settings.sv
hdl/core_hold_timer.sv
hdl/core_control_fsm.sv
video/video_output.sv
hdl/core_top.sv
sim/tb_core_top.sv

//--- sim/tb_tasks.svh
/*
 * testbench tasks
 * bus drivers, typed compares, bounded waits and the directed tests
 */

`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

// signals that the bounded wait can watch
localparam int sig_core_reset    = 0;
localparam int sig_cart_download = 1;
localparam int sig_video_hs      = 2;

////////////////////////////////////////
// compares

task automatic compare_data(input string what, input core_pkg::bridge_data_t got,
                            input core_pkg::bridge_data_t exp);
  check_count++;
  if (got !== exp) begin
    error_count++;
    $display("Mismatch at %0t ns: %s got %h, expected %h", $time, what, got, exp);
  end
endtask

task automatic compare_video(input string what, input core_pkg::video_word_t got,
                             input core_pkg::video_word_t exp);
  check_count++;
  if (got !== exp) begin
    error_count++;
    $display("Mismatch at %0t ns: %s got %h, expected %h", $time, what, got, exp);
  end
endtask

task automatic compare_bit(input string what, input logic got, input logic exp);
  check_count++;
  if (got !== exp) begin
    error_count++;
    $display("Mismatch at %0t ns: %s got %b, expected %b", $time, what, got, exp);
  end
endtask

task automatic compare_count(input string what, input int got, input int exp);
  check_count++;
  if (got != exp) begin
    error_count++;
    $display("Mismatch at %0t ns: %s got %0d cycles, expected %0d", $time, what, got, exp);
  end
endtask

////////////////////////////////////////
// drivers and waits

function automatic logic probe(input int which);
  case (which)
    sig_core_reset:    probe = core_reset;
    sig_cart_download: probe = cart_download;
    default:           probe = video_hs;
  endcase
endfunction

// counts falling edges until the level shows or the limit runs out
task automatic wait_level(input string what, input int which, input logic level,
                          input int limit, output int cycles);
  cycles = 0;
  #1;
  while (probe(which) !== level && cycles < limit) begin
    @(negedge clk_74a);
    #1;
    cycles++;
  end
  if (probe(which) !== level) begin
    error_count++;
    $display("Timeout at %0t ns: %s did not reach %b within %0d cycles",
             $time, what, level, limit);
  end
endtask

task automatic bridge_write(input core_pkg::bridge_addr_t addr,
                            input core_pkg::bridge_data_t data);
  @(negedge clk_74a);
  bridge_addr    = addr;
  bridge_wr_data = data;
  bridge_wr      = 1'b1;
  @(negedge clk_74a);
  bridge_wr      = 1'b0;
endtask

task automatic pulse_dataslot(input logic req, input logic done);
  @(negedge clk_74a);
  dataslot_requestwrite = req;
  dataslot_allcomplete  = done;
  @(negedge clk_74a);
  dataslot_requestwrite = 1'b0;
  dataslot_allcomplete  = 1'b0;
endtask

// slot 2 covers every divider from 2 up
function automatic core_pkg::video_word_t end_of_line_word(input logic [1:0] div,
                                                           input logic ov);
  core_pkg::video_word_t w;
  w              = '0;
  w.eol.slot     = (div < 2'd2) ? div : 2'd2;
  w.eol.overscan = ov;
  return w;
endfunction

task automatic drive_video(input logic hb, input logic vb, input logic bd,
                           input core_pkg::video_word_t colour);
  logic                  exp_de;
  core_pkg::video_word_t exp_rgb;
  @(negedge clk_74a);
  hblank        = hb;
  vblank        = vb;
  border_active = bd;
  rgb_core      = colour;
  #1;
  exp_de = !hb && !vb && !bd;
  if (exp_de) begin
    exp_rgb = colour;
  end else if (last_de) begin
    exp_rgb = end_of_line_word(dotclock_divider, exp_overscan);
  end else begin
    exp_rgb = '0;
  end
  compare_bit("video_de", video_de, exp_de);
  compare_video("video_rgb", video_rgb, exp_rgb);
  last_de = exp_de;
endtask

////////////////////////////////////////
// directed tests

task automatic settings_writes();
  logic [31:0] d;
  logic        e_sgx;
  logic        e_bd;
  logic        e_mb;
  e_sgx = 1'b0;
  e_bd  = 1'b0;
  for (int round = 0; round < 4; round++) begin
    d = $urandom;
    bridge_write(core_pkg::addr_sgx, d);
    e_sgx = d[0];
    d = $urandom;
    bridge_write(core_pkg::addr_overscan, d);
    exp_overscan = d[0];
    d = $urandom;
    bridge_write(core_pkg::addr_border, d);
    e_bd = d[0];
    // alternate the save size so both table values show up
    d    = $urandom;
    d[0] = round[0];
    bridge_write(core_pkg::addr_mb128, d);
    e_mb = d[0];
    @(negedge clk_74a);
    #1;
    compare_data("datatable_data", datatable_data, e_mb ? 32'h0002_0000 : 32'h0000_0800);
    compare_data("datatable_addr", {22'd0, datatable_addr}, 32'd3);
    compare_bit("datatable_wren", datatable_wren, 1'b1);
    // unused address leaves every setting alone
    d = $urandom;
    bridge_write(32'h0000_0008, d);
    #1;
    compare_bit("sgx", sgx, e_sgx);
    compare_bit("overscan", overscan, exp_overscan);
    compare_bit("border", border, e_bd);
  end
endtask

task automatic read_mux();
  logic [31:0] r;
  for (int i = 0; i < 4; i++) begin
    r = $urandom;
    @(negedge clk_74a);
    save_rd_data = $urandom;
    cmd_rd_data  = $urandom;
    bridge_addr  = {4'h2, r[27:0]};
    #1;
    compare_data("save region read", bridge_rd_data, save_rd_data);
    @(negedge clk_74a);
    bridge_addr = {8'hF8, r[23:0]};
    #1;
    compare_data("command region read", bridge_rd_data, cmd_rd_data);
    @(negedge clk_74a);
    bridge_addr = {4'h5, r[27:0]};
    #1;
    compare_data("unmapped read", bridge_rd_data, 32'd0);
    @(negedge clk_74a);
    bridge_addr = {8'hF0, r[23:0]};
    #1;
    compare_data("near command region read", bridge_rd_data, 32'd0);
  end
endtask

task automatic core_hold();
  int n_rise;
  int n_fall;
  bridge_write(core_pkg::addr_core_hold, $urandom);
  wait_level("core_reset", sig_core_reset, 1'b1, 4, n_rise);
  compare_bit("core_reset rise within two cycles", n_rise <= 2, 1'b1);
  wait_level("core_reset", sig_core_reset, 1'b0, int'(hold_cycles) + 8, n_fall);
  compare_count("core_reset hold length", n_rise + n_fall, int'(hold_cycles) + 2);

  // host reset keeps the core held
  @(negedge clk_74a);
  host_reset_n = 1'b0;
  repeat (5) begin
    @(negedge clk_74a);
    #1;
    compare_bit("core_reset under host reset", core_reset, 1'b1);
  end
  @(negedge clk_74a);
  host_reset_n = 1'b1;
  wait_level("core_reset", sig_core_reset, 1'b0, 4, n_fall);
endtask

task automatic cart_and_save();
  int          n;
  logic [31:0] r;
  logic        exp_save;
  pulse_dataslot(1'b1, 1'b0);
  #1;
  compare_bit("cart_download after requestwrite", cart_download, 1'b1);
  repeat (3) begin
    @(negedge clk_74a);
    #1;
    compare_bit("cart_download held", cart_download, 1'b1);
  end
  pulse_dataslot(1'b0, 1'b1);
  wait_level("cart_download", sig_cart_download, 1'b0, 1, n);
  compare_count("cart_download fall delay", n, 0);

  for (int i = 0; i < 10; i++) begin
    r = $urandom;
    @(negedge clk_74a);
    case (i)
      0: begin
        dataslot_requestwrite_id = 16'd1;
        dataslot_requestread_id  = 16'd0;
        exp_save                 = 1'b1;
      end
      1: begin
        dataslot_requestwrite_id = 16'd0;
        dataslot_requestread_id  = 16'd0;
        exp_save                 = 1'b0;
      end
      2: begin
        dataslot_requestwrite_id = 16'd0;
        dataslot_requestread_id  = 16'd1;
        exp_save                 = 1'b1;
      end
      3: begin
        dataslot_requestwrite_id = 16'd7;
        dataslot_requestread_id  = 16'd9;
        exp_save                 = 1'b0;
      end
      default: begin
        // even ids never match the save slot
        dataslot_requestwrite_id = r[0] ? 16'd1 : {r[31:17], 1'b0};
        dataslot_requestread_id  = r[1] ? 16'd1 : {r[16:2], 1'b0};
        exp_save                 = r[0] || r[1];
      end
    endcase
    @(negedge clk_74a);
    #1;
    compare_bit("save_loading", save_loading, exp_save);
  end
endtask

task automatic video_enable();
  logic [31:0] r;
  logic [31:0] c;
  for (int ov = 0; ov < 2; ov++) begin
    bridge_write(core_pkg::addr_overscan, {31'd0, ov[0]});
    exp_overscan = ov[0];
    for (int div = 0; div < 4; div++) begin
      @(negedge clk_74a);
      dotclock_divider = div[1:0];
      c = $urandom;
      drive_video(1'b0, 1'b0, 1'b0, c[23:0]);
      c = $urandom;
      drive_video(1'b0, 1'b0, 1'b0, c[23:0]);
      // end of line and then a blank cycle
      c = $urandom;
      drive_video(1'b1, 1'b0, 1'b0, c[23:0]);
      c = $urandom;
      drive_video(1'b0, 1'b1, 1'b0, c[23:0]);
    end
  end
  for (int i = 0; i < 24; i++) begin
    r = $urandom;
    drive_video(r[0] & r[1], r[2] & r[3] & r[4], r[5] & r[6], r[31:8]);
  end
  drive_video(1'b1, 1'b1, 1'b0, 24'd0);
endtask

task automatic sync_pulses();
  int          n;
  logic [31:0] r;
  for (int k = 0; k < 3; k++) begin
    r = ($urandom % 3) + 1;
    for (int i = 0; i <= int'(r); i++) begin
      @(negedge clk_74a);
      vsync_core = 1'b1;
      #1;
      compare_bit("video_vs", video_vs, i == 0);
    end
    repeat (3) begin
      @(negedge clk_74a);
      vsync_core = 1'b0;
      #1;
      compare_bit("video_vs low", video_vs, 1'b0);
    end
  end

  for (int k = 0; k < 3; k++) begin
    @(negedge clk_74a);
    hsync_core = 1'b1;
    wait_level("video_hs", sig_video_hs, 1'b1, 10, n);
    compare_count("video_hs delay", n, int'(hs_delay));
    @(negedge clk_74a);
    #1;
    compare_bit("video_hs one cycle", video_hs, 1'b0);
    @(negedge clk_74a);
    hsync_core = 1'b0;
    repeat (8) begin
      @(negedge clk_74a);
      #1;
      compare_bit("video_hs quiet", video_hs, 1'b0);
    end
  end
endtask

`endif

//--- sim/tb_core_top.sv
/*
 * core top testbench
 * clock, reset, DUT instance and the directed test sequence
 */

`timescale 1ns/1ns
`default_nettype none

module tb_core_top;

  localparam logic [31:0] hold_cycles = 32'd20;
  localparam logic [2:0]  hs_delay    = 3'd6;

  logic                       clk_74a;
  logic                       pll_core_locked;
  core_pkg::bridge_addr_t     bridge_addr;
  logic                       bridge_wr;
  core_pkg::bridge_data_t     bridge_wr_data;
  core_pkg::bridge_data_t     bridge_rd_data;
  core_pkg::bridge_data_t     save_rd_data;
  core_pkg::bridge_data_t     cmd_rd_data;
  logic                       sgx;
  logic                       overscan;
  logic                       border;
  core_pkg::datatable_addr_t  datatable_addr;
  core_pkg::bridge_data_t     datatable_data;
  logic                       datatable_wren;
  logic                       host_reset_n;
  logic                       dataslot_requestwrite;
  logic                       dataslot_allcomplete;
  core_pkg::slot_id_t         dataslot_requestwrite_id;
  core_pkg::slot_id_t         dataslot_requestread_id;
  logic                       core_reset;
  logic                       cart_download;
  logic                       save_loading;
  logic                       hblank;
  logic                       vblank;
  logic                       border_active;
  logic                       hsync_core;
  logic                       vsync_core;
  core_pkg::video_word_t      rgb_core;
  core_pkg::dotclock_t        dotclock_divider;
  core_pkg::video_word_t      video_rgb;
  logic                       video_de;
  logic                       video_hs;
  logic                       video_vs;

  // scoreboard state
  int   check_count;
  int   error_count;
  logic exp_overscan;
  logic last_de;

  core_top #(
    .HOLD_CYCLES (hold_cycles),
    .HS_DELAY    (hs_delay)
  ) uut (
    .clk_74a                  (clk_74a),
    .pll_core_locked          (pll_core_locked),
    .bridge_addr              (bridge_addr),
    .bridge_wr                (bridge_wr),
    .bridge_wr_data           (bridge_wr_data),
    .bridge_rd_data           (bridge_rd_data),
    .save_rd_data             (save_rd_data),
    .cmd_rd_data              (cmd_rd_data),
    .sgx                      (sgx),
    .overscan                 (overscan),
    .border                   (border),
    .datatable_addr           (datatable_addr),
    .datatable_data           (datatable_data),
    .datatable_wren           (datatable_wren),
    .host_reset_n             (host_reset_n),
    .dataslot_requestwrite    (dataslot_requestwrite),
    .dataslot_allcomplete     (dataslot_allcomplete),
    .dataslot_requestwrite_id (dataslot_requestwrite_id),
    .dataslot_requestread_id  (dataslot_requestread_id),
    .core_reset               (core_reset),
    .cart_download            (cart_download),
    .save_loading             (save_loading),
    .hblank                   (hblank),
    .vblank                   (vblank),
    .border_active            (border_active),
    .hsync_core               (hsync_core),
    .vsync_core               (vsync_core),
    .rgb_core                 (rgb_core),
    .dotclock_divider         (dotclock_divider),
    .video_rgb                (video_rgb),
    .video_de                 (video_de),
    .video_hs                 (video_hs),
    .video_vs                 (video_vs)
  );

  // 8 ns period
  always #4 clk_74a = ~clk_74a;

  `include "tb_tasks.svh"

  ////////////////////////////////////////
  // test sequence

  initial begin
    void'($urandom(32'h0dea_c261));
    check_count              = 0;
    error_count              = 0;
    exp_overscan             = 1'b0;
    last_de                  = 1'b0;
    clk_74a                  = 1'b0;
    pll_core_locked          = 1'b0;
    bridge_addr              = '0;
    bridge_wr                = 1'b0;
    bridge_wr_data           = '0;
    save_rd_data             = '0;
    cmd_rd_data              = '0;
    host_reset_n             = 1'b1;
    dataslot_requestwrite    = 1'b0;
    dataslot_allcomplete     = 1'b0;
    dataslot_requestwrite_id = '0;
    dataslot_requestread_id  = '0;
    hblank                   = 1'b1;
    vblank                   = 1'b1;
    border_active            = 1'b0;
    hsync_core               = 1'b0;
    vsync_core               = 1'b0;
    rgb_core                 = '0;
    dotclock_divider         = '0;

    // two cycles of reset
    repeat (2) @(negedge clk_74a);
    pll_core_locked = 1'b1;
    #1;
    compare_bit("core_reset after reset", core_reset, 1'b1);
    compare_bit("cart_download after reset", cart_download, 1'b0);
    compare_bit("save_loading after reset", save_loading, 1'b0);
    compare_bit("datatable_wren after reset", datatable_wren, 1'b0);
    compare_bit("sgx after reset", sgx, 1'b0);

    settings_writes();
    read_mux();
    core_hold();
    cart_and_save();
    video_enable();
    sync_pulses();

    $display("checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- video/video_output.sv
/*
 * video output
 * data enable from blanking and border, single cycle vsync,
 * delayed hsync and the end-of-line word for the scaler
 */

`timescale 1ns/1ns
`default_nettype none

module video_output #(
  parameter logic [2:0] HS_DELAY = 3'd6
) (
  input  wire                    clk_74a,
  input  wire                    pll_core_locked,
  input  wire                    hblank,
  input  wire                    vblank,
  input  wire                    border_active,
  input  wire                    hsync_core,
  input  wire                    vsync_core,
  input  core_pkg::video_word_t  rgb_core,
  input  wire                    overscan,
  input  core_pkg::dotclock_t    dotclock_divider,
  output core_pkg::video_word_t  video_rgb,
  output logic                   video_de,
  output logic                   video_hs,
  output logic                   video_vs
);

  logic                  de;
  logic                  de_prev;
  logic                  hs_prev;
  logic                  vs_prev;
  logic [2:0]            hs_delay;
  logic [1:0]            slot;
  core_pkg::video_word_t eol_word;

  ////////////////////////////////////////
  // data enable

  assign de       = !(hblank || vblank) && !border_active;
  assign video_de = de;

  ////////////////////////////////////////
  // edge history and hsync delay

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      de_prev  <= 1'b0;
      hs_prev  <= 1'b0;
      vs_prev  <= 1'b0;
      hs_delay <= '0;
    end else begin
      de_prev <= de;
      hs_prev <= hsync_core;
      vs_prev <= vsync_core;
      if (hsync_core && !hs_prev) begin
        // push hsync away from the vsync edge
        hs_delay <= HS_DELAY;
      end else if (hs_delay != '0) begin
        hs_delay <= hs_delay - 3'd1;
      end
    end
  end

  assign video_vs = vsync_core && !vs_prev;
  assign video_hs = (hs_delay == 3'd1);

  ////////////////////////////////////////
  // end of line word

  // 256 and 512 modes share slot 2
  assign slot = (dotclock_divider > 2'd1) ? 2'd2 : dotclock_divider;

  always_comb begin
    eol_word.eol.zero_hi  = '0;
    eol_word.eol.slot     = slot;
    eol_word.eol.overscan = overscan;
    eol_word.eol.zero_lo  = '0;
  end

  // colour during de, eol word on the first cycle after it
  always_comb begin
    if (de) begin
      video_rgb = rgb_core;
    end else if (de_prev) begin
      video_rgb = eol_word;
    end else begin
      video_rgb = '0;
    end
  end

endmodule

`default_nettype wire
